// File: hdl/nx_config.svh
`ifndef NX_CONFIG_SVH
`define NX_CONFIG_SVH

// Width of the target address carried in the first beat
`define NX_TARGET_W 8

// Width of one stream beat
`define NX_BUS_W 8

// Full payload width, split into bus-wide chunks
`define NX_PAYLOAD_W 24

// Number of payload chunks
`define NX_CHUNKS 3

// Default number of beats buffered between transmitter and receiver
`define NX_FIFO_DEPTH 4

`endif

// File: hdl/nx_pkg.sv
`include "nx_config.svh"

package nx_pkg;

    // Commands, sent as the second beat of a message
    typedef enum logic [`NX_BUS_W-1:0] {
        NX_OP_READ   = 8'h01,
        NX_OP_WRITE  = 8'h02,
        NX_OP_NOTIFY = 8'h04,
        NX_OP_FLUSH  = 8'h08
    } nx_opcode_t;

    // One request into the transmitter
    typedef struct packed {
        logic [`NX_TARGET_W-1:0]  target;
        nx_opcode_t               command;
        logic [`NX_PAYLOAD_W-1:0] payload;
        logic [`NX_CHUNKS-1:0]    mask;
    } nx_request_t;

    // One beat of the byte stream
    typedef struct packed {
        logic [`NX_BUS_W-1:0] data;
        logic                 last;
    } nx_beat_t;

    // Reassembled message, chunks packed into the low positions
    typedef struct packed {
        logic [`NX_TARGET_W-1:0]  target;
        nx_opcode_t               command;
        logic [`NX_PAYLOAD_W-1:0] payload;
        logic [1:0]               count;
    } nx_message_t;

    typedef enum logic [1:0] {
        NX_TX_TARGET,
        NX_TX_COMMAND,
        NX_TX_PAYLOAD
    } nx_tx_state_t;

    typedef enum logic [1:0] {
        NX_RX_TARGET,
        NX_RX_COMMAND,
        NX_RX_PAYLOAD,
        NX_RX_HOLD
    } nx_rx_state_t;

endpackage

// File: hdl/nx_transmitter.sv
`timescale 1ns/1ns
`include "nx_config.svh"

module nx_transmitter (
    input  logic                clk,
    input  logic                rst,
    input  nx_pkg::nx_request_t req,
    input  logic                req_valid,
    output logic                req_ready,
    output nx_pkg::nx_beat_t    beat,
    output logic                beat_valid,
    input  logic                beat_ready
);

    localparam int CHUNK_IDX_W = $clog2(`NX_CHUNKS);

    nx_pkg::nx_tx_state_t     state_q;
    nx_pkg::nx_tx_state_t     state_d;
    logic [`NX_CHUNKS-1:0]    mask_q;
    logic [`NX_CHUNKS-1:0]    mask_d;
    nx_pkg::nx_opcode_t       command_q;
    nx_pkg::nx_opcode_t       command_d;
    logic [`NX_PAYLOAD_W-1:0] payload_q;
    logic [`NX_PAYLOAD_W-1:0] payload_d;
    nx_pkg::nx_beat_t         beat_q;
    nx_pkg::nx_beat_t         beat_d;
    logic                     beat_valid_q;
    logic                     beat_valid_d;
    logic                     started_q;
    logic                     out_free;
    logic                     req_fire;
    logic [CHUNK_IDX_W-1:0]   pick_idx;

    // Output register can load when empty or being drained this cycle
    assign out_free   = !beat_valid_q || beat_ready;
    assign req_ready  = started_q && (state_q == nx_pkg::NX_TX_TARGET) && out_free;
    assign req_fire   = req_valid && req_ready;
    assign beat       = beat_q;
    assign beat_valid = beat_valid_q;

    // Lowest chunk still pending, scanned from the top so the lowest wins
    always_comb begin : pick_chunk
        pick_idx = '0;
        for (int i = `NX_CHUNKS - 1; i >= 0; i--) begin
            if (mask_q[i]) begin
                pick_idx = CHUNK_IDX_W'(i);
            end
        end
    end

    always_comb begin : next_state
        state_d      = state_q;
        mask_d       = mask_q;
        command_d    = command_q;
        payload_d    = payload_q;
        beat_d       = beat_q;
        beat_valid_d = beat_valid_q;
        if (out_free) begin
            beat_valid_d = 1'b0;
            case (state_q)
                nx_pkg::NX_TX_TARGET: begin
                    // An empty mask is taken and dropped
                    if (req_fire && |req.mask) begin
                        command_d    = req.command;
                        payload_d    = req.payload;
                        mask_d       = req.mask;
                        beat_d.data  = req.target;
                        beat_d.last  = 1'b0;
                        beat_valid_d = 1'b1;
                        state_d      = nx_pkg::NX_TX_COMMAND;
                    end
                end
                nx_pkg::NX_TX_COMMAND: begin
                    beat_d.data  = command_q;
                    beat_d.last  = 1'b0;
                    beat_valid_d = 1'b1;
                    state_d      = nx_pkg::NX_TX_PAYLOAD;
                end
                nx_pkg::NX_TX_PAYLOAD: begin
                    beat_d.data      = payload_q[pick_idx*`NX_BUS_W +: `NX_BUS_W];
                    mask_d[pick_idx] = 1'b0;
                    beat_d.last      = ~|mask_d;
                    beat_valid_d     = 1'b1;
                    if (beat_d.last) begin
                        state_d = nx_pkg::NX_TX_TARGET;
                    end
                end
                default: begin
                    state_d = nx_pkg::NX_TX_TARGET;
                    mask_d  = '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin : tx_ctrl
        if (rst) begin
            state_q      <= nx_pkg::NX_TX_TARGET;
            mask_q       <= '0;
            beat_valid_q <= 1'b0;
            started_q    <= 1'b0;
        end else begin
            state_q      <= state_d;
            mask_q       <= mask_d;
            beat_valid_q <= beat_valid_d;
            // Requests are held off for one cycle out of reset
            started_q    <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin : tx_data
        command_q <= command_d;
        payload_q <= payload_d;
        beat_q    <= beat_d;
    end

    // A stalled beat must not change before the FIFO takes it
    assert property (@(posedge clk) disable iff (rst)
        beat_valid && !beat_ready |=> beat_valid && $stable(beat));

endmodule

// File: hdl/nx_stream_fifo.sv
`timescale 1ns/1ns
`include "nx_config.svh"

module nx_stream_fifo #(
    parameter int DEPTH = `NX_FIFO_DEPTH
) (
    input  logic             clk,
    input  logic             rst,
    input  nx_pkg::nx_beat_t in_beat,
    input  logic             in_valid,
    output logic             in_ready,
    output nx_pkg::nx_beat_t out_beat,
    output logic             out_valid,
    input  logic             out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    nx_pkg::nx_beat_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_beat  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin : fifo_mem
        if (push) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    always_ff @(posedge clk or posedge rst) begin : fifo_ctrl
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the count unchanged
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        count <= CNT_W'(DEPTH));

endmodule

// File: hdl/nx_receiver.sv
`timescale 1ns/1ns
`include "nx_config.svh"

module nx_receiver (
    input  logic                clk,
    input  logic                rst,
    input  nx_pkg::nx_beat_t    beat,
    input  logic                beat_valid,
    output logic                beat_ready,
    output nx_pkg::nx_message_t msg,
    output logic                msg_valid,
    input  logic                msg_ready
);

    nx_pkg::nx_rx_state_t     state_q;
    logic [1:0]               count_q;
    logic [`NX_TARGET_W-1:0]  target_q;
    nx_pkg::nx_opcode_t       command_q;
    logic [`NX_PAYLOAD_W-1:0] payload_q;
    logic                     beat_fire;

    // Stream is stalled while a finished message waits
    assign beat_ready = (state_q != nx_pkg::NX_RX_HOLD);
    assign beat_fire  = beat_valid && beat_ready;
    assign msg_valid  = (state_q == nx_pkg::NX_RX_HOLD);

    always_comb begin : drive_msg
        msg.target  = target_q;
        msg.command = command_q;
        msg.payload = payload_q;
        msg.count   = count_q;
    end

    always_ff @(posedge clk or posedge rst) begin : rx_ctrl
        if (rst) begin
            state_q <= nx_pkg::NX_RX_TARGET;
            count_q <= '0;
        end else begin
            case (state_q)
                nx_pkg::NX_RX_TARGET: begin
                    if (beat_fire) begin
                        count_q <= '0;
                        state_q <= nx_pkg::NX_RX_COMMAND;
                    end
                end
                nx_pkg::NX_RX_COMMAND: begin
                    if (beat_fire) begin
                        state_q <= beat.last ? nx_pkg::NX_RX_HOLD : nx_pkg::NX_RX_PAYLOAD;
                    end
                end
                nx_pkg::NX_RX_PAYLOAD: begin
                    if (beat_fire) begin
                        count_q <= count_q + 1'b1;
                        if (beat.last) begin
                            state_q <= nx_pkg::NX_RX_HOLD;
                        end
                    end
                end
                nx_pkg::NX_RX_HOLD: begin
                    if (msg_ready) begin
                        state_q <= nx_pkg::NX_RX_TARGET;
                    end
                end
                default: begin
                    state_q <= nx_pkg::NX_RX_TARGET;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin : rx_data
        if (beat_fire) begin
            case (state_q)
                nx_pkg::NX_RX_TARGET: begin
                    target_q  <= beat.data;
                    // Unfilled high chunks read back as zero
                    payload_q <= '0;
                end
                nx_pkg::NX_RX_COMMAND: begin
                    command_q <= nx_pkg::nx_opcode_t'(beat.data);
                end
                nx_pkg::NX_RX_PAYLOAD: begin
                    // Chunks land in arrival order from the bottom up
                    payload_q[count_q*`NX_BUS_W +: `NX_BUS_W] <= beat.data;
                end
                default: begin
                end
            endcase
        end
    end

    // The sender never produces more chunks than the payload holds
    assert property (@(posedge clk) disable iff (rst)
        beat_fire && (state_q == nx_pkg::NX_RX_PAYLOAD) |-> count_q < `NX_CHUNKS);

endmodule

// File: hdl/nx_link.sv
`timescale 1ns/1ns
`include "nx_config.svh"

module nx_link (
    input  logic                clk,
    input  logic                rst,
    input  nx_pkg::nx_request_t req,
    input  logic                req_valid,
    output logic                req_ready,
    output nx_pkg::nx_message_t msg,
    output logic                msg_valid,
    input  logic                msg_ready
);

    // Transmitter to FIFO
    nx_pkg::nx_beat_t tx_beat;
    logic             tx_valid;
    logic             tx_ready;

    // FIFO to receiver
    nx_pkg::nx_beat_t rx_beat;
    logic             rx_valid;
    logic             rx_ready;

    nx_transmitter u_tx (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .beat       (tx_beat),
        .beat_valid (tx_valid),
        .beat_ready (tx_ready)
    );

    nx_stream_fifo #(
        .DEPTH (`NX_FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (tx_beat),
        .in_valid  (tx_valid),
        .in_ready  (tx_ready),
        .out_beat  (rx_beat),
        .out_valid (rx_valid),
        .out_ready (rx_ready)
    );

    nx_receiver u_rx (
        .clk        (clk),
        .rst        (rst),
        .beat       (rx_beat),
        .beat_valid (rx_valid),
        .beat_ready (rx_ready),
        .msg        (msg),
        .msg_valid  (msg_valid),
        .msg_ready  (msg_ready)
    );

endmodule

// File: verif/nx_link_tb.sv
`timescale 1ns/1ns
`include "nx_config.svh"

module nx_link_tb;

    localparam int CLK_PERIOD = 4;
    localparam logic [31:0] SEED = 32'h1b15_eb72;
    localparam int N_FULL = 12;
    localparam int N_SPARSE = 18;
    localparam int N_ZERO = 16;
    localparam int N_RANDOM = 200;
    localparam int N_OPCODE = 8;
    localparam int N_TOTAL = N_FULL + N_SPARSE + N_ZERO + N_RANDOM + N_OPCODE;
    // Worst case of 20 cycles per message, plus reset and drain margin
    localparam int TIMEOUT_NS = N_TOTAL * 20 * CLK_PERIOD + 1000;

    logic                clk;
    logic                rst;
    nx_pkg::nx_request_t req;
    logic                req_valid;
    logic                req_ready;
    nx_pkg::nx_message_t msg;
    logic                msg_valid;
    logic                msg_ready;

    logic                bp_enable;
    logic [31:0]         stim_state;
    logic [31:0]         bp_state;
    int                  pass_count;
    int                  fail_count;
    nx_pkg::nx_message_t exp_q[$];

    nx_link dut (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .msg       (msg),
        .msg_valid (msg_valid),
        .msg_ready (msg_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Set chunks are packed from the bottom in ascending chunk order
    function automatic nx_pkg::nx_message_t expected_message(input nx_pkg::nx_request_t r);
        nx_pkg::nx_message_t m;
        int n;
        m.target  = r.target;
        m.command = r.command;
        m.payload = '0;
        n = 0;
        for (int i = 0; i < `NX_CHUNKS; i++) begin
            if (r.mask[i]) begin
                m.payload[n*`NX_BUS_W +: `NX_BUS_W] = r.payload[i*`NX_BUS_W +: `NX_BUS_W];
                n++;
            end
        end
        m.count = 2'(n);
        return m;
    endfunction

    function automatic nx_pkg::nx_opcode_t opcode_at(input int idx);
        case (idx % 4)
            0: return nx_pkg::NX_OP_READ;
            1: return nx_pkg::NX_OP_WRITE;
            2: return nx_pkg::NX_OP_NOTIFY;
            default: return nx_pkg::NX_OP_FLUSH;
        endcase
    endfunction

    task automatic check_message(input nx_pkg::nx_message_t expected,
                                 input nx_pkg::nx_message_t actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: message expected target=%h command=%h payload=%h count=%0d",
                     $time, expected.target, expected.command, expected.payload, expected.count);
            $display("    got target=%h command=%h payload=%h count=%0d",
                     actual.target, actual.command, actual.payload, actual.count);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_idle(input logic exp_ready, input string phase);
        if (req_ready !== exp_ready || msg_valid !== 1'b0) begin
            $display("MISMATCH at %0t: %s, req_ready expected %b got %b, msg_valid got %b",
                     $time, phase, exp_ready, req_ready, msg_valid);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send_request(input nx_pkg::nx_request_t r);
        req       = r;
        req_valid = 1'b1;
        while (req_ready !== 1'b1) begin
            @(negedge clk);
        end
        if (|r.mask) begin
            exp_q.push_back(expected_message(r));
        end
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic issue_random_request(input logic [`NX_CHUNKS-1:0] mask,
                                        input nx_pkg::nx_opcode_t op);
        nx_pkg::nx_request_t r;
        stim_state = xorshift32(stim_state);
        r.target   = stim_state[31:24];
        r.payload  = stim_state[23:0];
        r.command  = op;
        r.mask     = mask;
        send_request(r);
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (fail_count == errs_before) begin
            $display("Test %s: passed", name);
        end else begin
            $display("Test %s: failed with %0d errors", name, fail_count - errs_before);
        end
    endtask

    // Random back-pressure on the message side
    always @(negedge clk) begin : drive_msg_ready
        if (bp_enable) begin
            bp_state  = xorshift32(bp_state);
            msg_ready = bp_state[7];
        end else begin
            msg_ready = 1'b1;
        end
    end

    always @(posedge clk) begin : compare_messages
        nx_pkg::nx_message_t exp_msg;
        if (!rst && msg_valid && msg_ready) begin
            if (exp_q.size() == 0) begin
                $display("ERROR at %0t: a message arrived when none was expected", $time);
                fail_count++;
            end else begin
                exp_msg = exp_q.pop_front();
                check_message(exp_msg, msg);
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Run timed out with %0d messages outstanding", exp_q.size());
        $display("Finished with errors");
        $finish;
    end

    initial begin : stimulus
        int errs;
        logic [`NX_CHUNKS-1:0] mask;
        clk        = 1'b0;
        rst        = 1'b1;
        req        = '0;
        req_valid  = 1'b0;
        msg_ready  = 1'b0;
        bp_enable  = 1'b0;
        stim_state = SEED;
        bp_state   = xorshift32(SEED);
        pass_count = 0;
        fail_count = 0;

        repeat (5) @(posedge clk);
        @(negedge clk);
        errs = fail_count;
        check_idle(1'b0, "during reset");
        rst = 1'b0;
        check_idle(1'b0, "first cycle after reset");
        @(negedge clk);
        check_idle(1'b1, "second cycle after reset");
        report_test("reset state", errs);

        errs = fail_count;
        for (int i = 0; i < N_FULL; i++) begin
            issue_random_request('1, opcode_at(i));
        end
        wait_drained();
        report_test("full mask", errs);

        errs = fail_count;
        for (int m = 1; m <= 6; m++) begin
            repeat (N_SPARSE / 6) issue_random_request(m[`NX_CHUNKS-1:0], opcode_at(m));
        end
        wait_drained();
        report_test("sparse masks", errs);

        // Every other request carries an empty mask
        errs = fail_count;
        for (int i = 0; i < N_ZERO; i++) begin
            mask = (i % 2 == 0) ? '0 : `NX_CHUNKS'(i % 7 + 1);
            issue_random_request(mask, opcode_at(i));
        end
        wait_drained();
        report_test("zero masks interleaved", errs);

        errs = fail_count;
        bp_enable = 1'b1;
        for (int i = 0; i < N_RANDOM; i++) begin
            stim_state = xorshift32(stim_state);
            issue_random_request(stim_state[`NX_CHUNKS-1:0], opcode_at(stim_state[9:8]));
        end
        wait_drained();
        bp_enable = 1'b0;
        report_test("random back-pressure", errs);

        errs = fail_count;
        for (int i = 0; i < N_OPCODE; i++) begin
            mask = (i < 4) ? '1 : `NX_CHUNKS'(3'b101);
            issue_random_request(mask, opcode_at(i));
        end
        wait_drained();
        report_test("all opcodes", errs);

        // Quiet period to catch any stray message
        repeat (10) @(negedge clk);
        $display("Checks passed: %0d, checks failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+hdl
hdl/nx_pkg.sv
hdl/nx_transmitter.sv
hdl/nx_stream_fifo.sv
hdl/nx_receiver.sv
hdl/nx_link.sv
verif/nx_link_tb.sv

// File: Bender.yml
package:
  name: nx_link

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/nx_pkg.sv
      - hdl/nx_transmitter.sv
      - hdl/nx_stream_fifo.sv
      - hdl/nx_receiver.sv
      - hdl/nx_link.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - verif/nx_link_tb.sv
